/* Bender.yml */
package:
  name: wb_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_arch_pkg.sv
      - hdl/wb_ctrl_pkg.sv
      - hdl/wb_ifs.sv
      - hdl/wb_commit_decode.sv
      - hdl/reg_csr_file.sv
      - hdl/trap_redirect.sv
      - hdl/wb_stage_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_wb_stage.sv

/* filelist.f */
+incdir+hdl
hdl/rv_arch_pkg.sv
hdl/wb_ctrl_pkg.sv
hdl/wb_ifs.sv
hdl/wb_commit_decode.sv
hdl/reg_csr_file.sv
hdl/trap_redirect.sv
hdl/wb_stage_top.sv
tb/tb_wb_stage.sv

/* hdl/reg_csr_file.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module reg_csr_file (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_arch_pkg::reg_idx_t  raddr1,
    input  rv_arch_pkg::reg_idx_t  raddr2,
    input  rv_arch_pkg::csr_addr_t csr_raddr,
    output rv_arch_pkg::word_t     rdata1,
    output rv_arch_pkg::word_t     rdata2,
    output rv_arch_pkg::word_t     csr_rdata,
    commit_if.dst                  commit,
    csr_view_if.src                csr
);

    // CSRs written through ports 1 and 2, in the order mtvec, mepc, mcause.
    localparam rv_arch_pkg::csr_addr_t PORT12_ADDR [3] = '{
        `WB_CSR_MTVEC, `WB_CSR_MEPC, `WB_CSR_MCAUSE
    };

    rv_arch_pkg::word_t rf [32];
    rv_arch_pkg::word_t mstatus;
    rv_arch_pkg::word_t csr12 [3];
    rv_arch_pkg::word_t mtvec;
    rv_arch_pkg::word_t mepc;
    rv_arch_pkg::word_t mcause;

    logic gpr_we;
    logic csr_we;
    logic is_mstatus_r;
    logic is_mtvec_r;
    logic is_mepc_r;
    logic is_mcause_r;

    assign gpr_we = commit.valid && commit.rd_wen && (commit.rd != '0); // x0 drops writes.
    assign csr_we = commit.valid && commit.csr_wen;

    always_ff @(posedge clk) begin
        if (gpr_we) begin
            rf[commit.rd] <= commit.rd_data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
        end else if (csr_we && commit.csr_waddr3 == `WB_CSR_MSTATUS) begin
            mstatus <= commit.csr_wdata3;
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_csr12
        always_ff @(posedge clk) begin
            if (rst) begin
                csr12[i] <= '0;
            end else if (csr_we) begin
                if (commit.csr_waddr1 == PORT12_ADDR[i]) begin
                    csr12[i] <= commit.csr_wdata1;
                end else if (commit.csr_waddr2 == PORT12_ADDR[i]) begin
                    csr12[i] <= commit.csr_wdata2;
                end
            end
        end
    end

    assign mtvec  = csr12[0];
    assign mepc   = csr12[1];
    assign mcause = csr12[2];

    assign csr.mstatus = mstatus;
    assign csr.mtvec   = mtvec;
    assign csr.mepc    = mepc;

    // one-hot select, so an unknown address falls through to zero.
    assign is_mstatus_r = (csr_raddr == `WB_CSR_MSTATUS);
    assign is_mtvec_r   = (csr_raddr == `WB_CSR_MTVEC);
    assign is_mepc_r    = (csr_raddr == `WB_CSR_MEPC);
    assign is_mcause_r  = (csr_raddr == `WB_CSR_MCAUSE);

    assign csr_rdata = ({`WB_XLEN{is_mstatus_r}} & mstatus) |
                       ({`WB_XLEN{is_mtvec_r}}   & mtvec)   |
                       ({`WB_XLEN{is_mepc_r}}    & mepc)    |
                       ({`WB_XLEN{is_mcause_r}}  & mcause);

endmodule

/* hdl/rv_arch_pkg.sv */
`include "wb_consts.svh"

package rv_arch_pkg;

    // one data word, as held by a GPR or a CSR.
    typedef logic [`WB_XLEN-1:0] word_t;

    typedef logic [`WB_REG_ADDR_W-1:0] reg_idx_t; // x0 to x31.

    typedef logic [`WB_CSR_ADDR_W-1:0] csr_addr_t;

endpackage

/* hdl/trap_redirect.sv */
`timescale 1ns/1ps

module trap_redirect (
    input  logic               clk,
    input  logic               rst,
    output logic               next_inst,
    output logic               redirect_valid,
    output rv_arch_pkg::word_t redirect_pc,
    commit_if.dst              commit,
    csr_view_if.dst            csr
);

    logic is_ecall;
    logic is_mret;

    assign is_ecall = commit.valid && (commit.op == wb_ctrl_pkg::OP_ECALL);
    assign is_mret  = commit.valid && (commit.op == wb_ctrl_pkg::OP_MRET);

    always_ff @(posedge clk) begin
        if (rst) begin
            next_inst      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            next_inst      <= commit.valid; // one pulse per retired instruction.
            redirect_valid <= is_ecall || is_mret;
        end
    end

    // mtvec and mepc are sampled at the same edge that the trap writes land,
    // so the target is the value from before this instruction.
    always_ff @(posedge clk) begin
        if (is_ecall) begin
            redirect_pc <= csr.mtvec;
        end else if (is_mret) begin
            redirect_pc <= csr.mepc;
        end
    end

endmodule

/* hdl/wb_commit_decode.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_commit_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  rv_arch_pkg::word_t      ex_pc,
    input  logic                    ex_rd_wen,
    input  rv_arch_pkg::reg_idx_t   ex_rd,
    input  rv_arch_pkg::word_t      ex_result,
    input  wb_ctrl_pkg::commit_op_e ex_op,
    input  rv_arch_pkg::csr_addr_t  ex_csr_addr,
    input  rv_arch_pkg::word_t      ex_csr_wdata,
    output logic                    wb_ready,
    commit_if.src                   commit,
    csr_view_if.dst                 csr
);

    rv_arch_pkg::csr_addr_t csr_addr_q;
    rv_arch_pkg::word_t     csr_wdata_q;
    rv_arch_pkg::word_t     mstatus_ecall;
    rv_arch_pkg::word_t     mstatus_mret;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ready     <= 1'b0;
            commit.valid <= 1'b0;
        end else begin
            wb_ready     <= 1'b1; // rises on the first edge out of reset.
            commit.valid <= ex_valid;
        end
    end

    // the packet itself is only taken when execute presents one.
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            commit.op      <= ex_op;
            commit.pc      <= ex_pc;
            commit.rd_wen  <= ex_rd_wen;
            commit.rd      <= ex_rd;
            commit.rd_data <= ex_result;
            csr_addr_q     <= ex_csr_addr;
            csr_wdata_q    <= ex_csr_wdata;
        end
    end

    // trap entry stacks MIE into MPIE, trap return restores it.
    always_comb begin
        mstatus_ecall = csr.mstatus;
        mstatus_ecall[`WB_MSTATUS_MPIE] = csr.mstatus[`WB_MSTATUS_MIE];
        mstatus_ecall[`WB_MSTATUS_MIE]  = 1'b0;

        mstatus_mret = csr.mstatus;
        mstatus_mret[`WB_MSTATUS_MIE]  = csr.mstatus[`WB_MSTATUS_MPIE];
        mstatus_mret[`WB_MSTATUS_MPIE] = 1'b1;
    end

    assign commit.csr_wen = (commit.op != wb_ctrl_pkg::OP_NONE);

    always_comb begin
        commit.csr_waddr1 = '0; // address 0 matches no CSR, so the port is idle.
        commit.csr_wdata1 = '0;
        commit.csr_waddr2 = '0;
        commit.csr_wdata2 = '0;
        commit.csr_waddr3 = '0;
        commit.csr_wdata3 = '0;
        case (commit.op)
            wb_ctrl_pkg::OP_CSRW: begin
                if (csr_addr_q == `WB_CSR_MSTATUS) begin
                    commit.csr_waddr3 = csr_addr_q;
                    commit.csr_wdata3 = csr_wdata_q;
                end else begin
                    commit.csr_waddr1 = csr_addr_q;
                    commit.csr_wdata1 = csr_wdata_q;
                end
            end
            wb_ctrl_pkg::OP_ECALL: begin
                commit.csr_waddr1 = `WB_CSR_MEPC;
                commit.csr_wdata1 = commit.pc;
                commit.csr_waddr2 = `WB_CSR_MCAUSE;
                commit.csr_wdata2 = rv_arch_pkg::word_t'(`WB_CAUSE_ECALL_M);
                commit.csr_waddr3 = `WB_CSR_MSTATUS;
                commit.csr_wdata3 = mstatus_ecall;
            end
            wb_ctrl_pkg::OP_MRET: begin
                commit.csr_waddr3 = `WB_CSR_MSTATUS;
                commit.csr_wdata3 = mstatus_mret;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// architectural widths.
`define WB_XLEN       32
`define WB_REG_ADDR_W 5
`define WB_CSR_ADDR_W 12

// machine-mode CSR addresses.
`define WB_CSR_MSTATUS 12'h300
`define WB_CSR_MTVEC   12'h305
`define WB_CSR_MEPC    12'h341
`define WB_CSR_MCAUSE  12'h342

// mstatus bit positions.
`define WB_MSTATUS_MIE  3
`define WB_MSTATUS_MPIE 7

`define WB_CAUSE_ECALL_M 11 // environment call from M-mode.

`endif

/* hdl/wb_ctrl_pkg.sv */
package wb_ctrl_pkg;

    // kind of instruction retiring in write-back.
    // only csrrw writes a CSR, the other two are the trap entry and return.
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_CSRW  = 2'd1,
        OP_ECALL = 2'd2,
        OP_MRET  = 2'd3
    } commit_op_e;

endpackage

/* hdl/wb_ifs.sv */
`timescale 1ns/1ps

// one retiring instruction, already turned into register-file write requests.
interface commit_if;
    logic                    valid;
    wb_ctrl_pkg::commit_op_e op;
    rv_arch_pkg::word_t      pc;

    logic                    rd_wen;
    rv_arch_pkg::reg_idx_t   rd;
    rv_arch_pkg::word_t      rd_data;

    logic                    csr_wen;
    rv_arch_pkg::csr_addr_t  csr_waddr1; // port 1 wins over port 2.
    rv_arch_pkg::word_t      csr_wdata1;
    rv_arch_pkg::csr_addr_t  csr_waddr2;
    rv_arch_pkg::word_t      csr_wdata2;
    rv_arch_pkg::csr_addr_t  csr_waddr3; // only ever hits mstatus.
    rv_arch_pkg::word_t      csr_wdata3;

    modport src (
        output valid, op, pc,
        output rd_wen, rd, rd_data,
        output csr_wen,
        output csr_waddr1, csr_wdata1,
        output csr_waddr2, csr_wdata2,
        output csr_waddr3, csr_wdata3
    );

    modport dst (
        input valid, op, pc,
        input rd_wen, rd, rd_data,
        input csr_wen,
        input csr_waddr1, csr_wdata1,
        input csr_waddr2, csr_wdata2,
        input csr_waddr3, csr_wdata3
    );
endinterface

// live CSR values needed outside the register file.
interface csr_view_if;
    rv_arch_pkg::word_t mstatus;
    rv_arch_pkg::word_t mtvec;
    rv_arch_pkg::word_t mepc;

    modport src (output mstatus, mtvec, mepc);
    modport dst (input mstatus, mtvec, mepc);
endinterface

/* hdl/wb_stage_top.sv */
`timescale 1ns/1ps

module wb_stage_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    ex_valid,
    input  rv_arch_pkg::word_t      ex_pc,
    input  logic                    ex_rd_wen,
    input  rv_arch_pkg::reg_idx_t   ex_rd,
    input  rv_arch_pkg::word_t      ex_result,
    input  wb_ctrl_pkg::commit_op_e ex_op,
    input  rv_arch_pkg::csr_addr_t  ex_csr_addr,
    input  rv_arch_pkg::word_t      ex_csr_wdata,

    input  rv_arch_pkg::reg_idx_t   raddr1,
    input  rv_arch_pkg::reg_idx_t   raddr2,
    input  rv_arch_pkg::csr_addr_t  csr_raddr,
    output rv_arch_pkg::word_t      rdata1,
    output rv_arch_pkg::word_t      rdata2,
    output rv_arch_pkg::word_t      csr_rdata,

    output logic                    wb_ready,
    output logic                    next_inst,
    output logic                    redirect_valid,
    output rv_arch_pkg::word_t      redirect_pc
);

    commit_if   i_commit ();
    csr_view_if i_csr_view ();

    wb_commit_decode i_decode (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_rd_wen    (ex_rd_wen),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .ex_op        (ex_op),
        .ex_csr_addr  (ex_csr_addr),
        .ex_csr_wdata (ex_csr_wdata),
        .wb_ready     (wb_ready),
        .commit       (i_commit.src),
        .csr          (i_csr_view.dst)
    );

    reg_csr_file i_reg_csr_file (
        .clk       (clk),
        .rst       (rst),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .csr_raddr (csr_raddr),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .csr_rdata (csr_rdata),
        .commit    (i_commit.dst),
        .csr       (i_csr_view.src)
    );

    trap_redirect i_redirect (
        .clk            (clk),
        .rst            (rst),
        .next_inst      (next_inst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .commit         (i_commit.dst),
        .csr            (i_csr_view.dst)
    );

endmodule

/* tb/tb_wb_stage.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module tb_wb_stage;

    localparam int MAX_CYCLES = 2000; // the tests need about 300 cycles.

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    ex_valid;
    rv_arch_pkg::word_t      ex_pc;
    logic                    ex_rd_wen;
    rv_arch_pkg::reg_idx_t   ex_rd;
    rv_arch_pkg::word_t      ex_result;
    wb_ctrl_pkg::commit_op_e ex_op;
    rv_arch_pkg::csr_addr_t  ex_csr_addr;
    rv_arch_pkg::word_t      ex_csr_wdata;
    rv_arch_pkg::reg_idx_t   raddr1;
    rv_arch_pkg::reg_idx_t   raddr2;
    rv_arch_pkg::csr_addr_t  csr_raddr;
    rv_arch_pkg::word_t      rdata1;
    rv_arch_pkg::word_t      rdata2;
    rv_arch_pkg::word_t      csr_rdata;
    logic                    wb_ready;
    logic                    next_inst;
    logic                    redirect_valid;
    rv_arch_pkg::word_t      redirect_pc;

    // reference state, updated as each packet is presented.
    rv_arch_pkg::word_t gpr_model [32];
    bit                 gpr_known [32] = '{default: 1'b0};
    rv_arch_pkg::word_t m_mstatus = '0;
    rv_arch_pkg::word_t m_mtvec = '0;
    rv_arch_pkg::word_t m_mepc = '0;
    rv_arch_pkg::word_t m_mcause = '0;
    rv_arch_pkg::word_t lcg = 32'h1f21;
    int                 cycles = 0;
    string              test_name = "none";

    wb_stage_top i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles in test %s", cycles, test_name);
            $display("tests failed");
            $fatal(1);
        end
    end

    function automatic rv_arch_pkg::word_t lcg_step(input rv_arch_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string what, input rv_arch_pkg::word_t exp,
                              input rv_arch_pkg::word_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_idle(input logic ready);
        check_bit("wb_ready", ready, wb_ready);
        check_bit("next_inst", 1'b0, next_inst);
        check_bit("redirect_valid", 1'b0, redirect_valid);
    endtask

    // drives one packet with ex_valid high and applies it to the model.
    task automatic present_packet(input wb_ctrl_pkg::commit_op_e op, input rv_arch_pkg::word_t pc,
                                  input logic rd_wen, input rv_arch_pkg::reg_idx_t rd,
                                  input rv_arch_pkg::word_t result,
                                  input rv_arch_pkg::csr_addr_t csr_addr,
                                  input rv_arch_pkg::word_t csr_wdata);
        ex_valid = 1'b1;
        ex_op = op;
        ex_pc = pc;
        ex_rd_wen = rd_wen;
        ex_rd = rd;
        ex_result = result;
        ex_csr_addr = csr_addr;
        ex_csr_wdata = csr_wdata;
        if (rd_wen && rd != '0) begin
            gpr_model[rd] = result;
            gpr_known[rd] = 1'b1;
        end
        case (op)
            wb_ctrl_pkg::OP_CSRW: begin
                case (csr_addr)
                    `WB_CSR_MSTATUS: m_mstatus = csr_wdata;
                    `WB_CSR_MTVEC:   m_mtvec = csr_wdata;
                    `WB_CSR_MEPC:    m_mepc = csr_wdata;
                    `WB_CSR_MCAUSE:  m_mcause = csr_wdata;
                    default: ;
                endcase
            end
            wb_ctrl_pkg::OP_ECALL: begin
                m_mepc = pc;
                m_mcause = 32'd11;
                m_mstatus[`WB_MSTATUS_MPIE] = m_mstatus[`WB_MSTATUS_MIE];
                m_mstatus[`WB_MSTATUS_MIE] = 1'b0;
            end
            wb_ctrl_pkg::OP_MRET: begin
                m_mstatus[`WB_MSTATUS_MIE] = m_mstatus[`WB_MSTATUS_MPIE];
                m_mstatus[`WB_MSTATUS_MPIE] = 1'b1;
            end
            default: ;
        endcase
    endtask

    // returns inside the cycle where next_inst is expected high.
    task automatic retire(input wb_ctrl_pkg::commit_op_e op, input rv_arch_pkg::word_t pc,
                          input logic rd_wen, input rv_arch_pkg::reg_idx_t rd,
                          input rv_arch_pkg::word_t result,
                          input rv_arch_pkg::csr_addr_t csr_addr,
                          input rv_arch_pkg::word_t csr_wdata);
        @(negedge clk);
        present_packet(op, pc, rd_wen, rd, result, csr_addr, csr_wdata);
        @(negedge clk);
        ex_valid = 1'b0;
        check_bit("next_inst early", 1'b0, next_inst);
        @(negedge clk);
        check_bit("next_inst", 1'b1, next_inst);
        check_bit("redirect_valid",
                  op == wb_ctrl_pkg::OP_ECALL || op == wb_ctrl_pkg::OP_MRET, redirect_valid);
    endtask

    // each port in turn, with x0 on the other one.
    task automatic read_gpr(input rv_arch_pkg::reg_idx_t idx, input rv_arch_pkg::word_t exp);
        @(negedge clk);
        raddr1 = idx;
        raddr2 = '0;
        #1;
        check_word($sformatf("rdata1 x%0d", idx), exp, rdata1);
        check_word("rdata2 x0", '0, rdata2);
        @(negedge clk);
        raddr1 = '0;
        raddr2 = idx;
        #1;
        check_word("rdata1 x0", '0, rdata1);
        check_word($sformatf("rdata2 x%0d", idx), exp, rdata2);
    endtask

    task automatic read_csr(input rv_arch_pkg::csr_addr_t addr, input rv_arch_pkg::word_t exp);
        @(negedge clk);
        csr_raddr = addr;
        #1;
        check_word($sformatf("csr_rdata %h", addr), exp, csr_rdata);
    endtask

    task automatic check_csrs();
        read_csr(`WB_CSR_MSTATUS, m_mstatus);
        read_csr(`WB_CSR_MTVEC, m_mtvec);
        read_csr(`WB_CSR_MEPC, m_mepc);
        read_csr(`WB_CSR_MCAUSE, m_mcause);
    endtask

    task automatic test_reset();
        test_name = "reset";
        repeat (8) begin
            @(negedge clk);
            check_idle(1'b0);
        end
        rst = 1'b0;
        #1;
        check_idle(1'b0);
        @(negedge clk);
        check_idle(1'b1);
        check_csrs();
    endtask

    task automatic test_gpr();
        test_name = "gpr";
        for (int r = 1; r < 6; r++) begin
            retire(wb_ctrl_pkg::OP_NONE, 32'h8000_0000 + 4 * r, 1'b1,
                   rv_arch_pkg::reg_idx_t'(r), 32'h0101_0101 * r, '0, '0);
            read_gpr(rv_arch_pkg::reg_idx_t'(r), 32'h0101_0101 * r);
        end
        retire(wb_ctrl_pkg::OP_NONE, 32'h8000_0020, 1'b1, '0, 32'hdead_beef, '0, '0);
        read_gpr('0, '0);
    endtask

    task automatic test_csr();
        test_name = "csr";
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0100, 1'b0, '0, '0, `WB_CSR_MSTATUS, 32'h1888);
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0104, 1'b0, '0, '0, `WB_CSR_MTVEC, 32'h8000_0100);
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0108, 1'b0, '0, '0, `WB_CSR_MEPC, 32'h8000_0200);
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_010c, 1'b0, '0, '0, `WB_CSR_MCAUSE, 32'h5);
        check_csrs();
        read_csr(12'h344, '0); // not implemented.
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0110, 1'b1, 5'd7, 32'h7777_0007,
               `WB_CSR_MTVEC, 32'h8000_0300);
        read_gpr(5'd7, 32'h7777_0007);
        read_csr(`WB_CSR_MTVEC, 32'h8000_0300);
    endtask

    task automatic test_ecall();
        rv_arch_pkg::word_t target;
        test_name = "ecall";
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0200, 1'b0, '0, '0, `WB_CSR_MTVEC, 32'h8000_0400);
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0204, 1'b0, '0, '0, `WB_CSR_MSTATUS, 32'h8);
        target = m_mtvec;
        retire(wb_ctrl_pkg::OP_ECALL, 32'h8000_1234, 1'b0, '0, '0, '0, '0);
        check_word("redirect_pc", target, redirect_pc);
        read_csr(`WB_CSR_MEPC, 32'h8000_1234);
        read_csr(`WB_CSR_MCAUSE, 32'd11);
        read_csr(`WB_CSR_MSTATUS, 32'h80); // MIE cleared, MPIE holds the old MIE.
    endtask

    task automatic test_mret();
        test_name = "mret";
        retire(wb_ctrl_pkg::OP_MRET, 32'h8000_0400, 1'b0, '0, '0, '0, '0);
        check_word("redirect_pc", 32'h8000_1234, redirect_pc);
        read_csr(`WB_CSR_MSTATUS, 32'h88);
        retire(wb_ctrl_pkg::OP_CSRW, 32'h8000_0404, 1'b0, '0, '0, `WB_CSR_MSTATUS, 32'h8);
        retire(wb_ctrl_pkg::OP_MRET, 32'h8000_0408, 1'b0, '0, '0, '0, '0);
        check_word("redirect_pc", 32'h8000_1234, redirect_pc);
        read_csr(`WB_CSR_MSTATUS, 32'h80); // MPIE was 0, so MIE follows it down.
        check_csrs();
    endtask

    task automatic test_random_gprs();
        rv_arch_pkg::reg_idx_t rd;
        rv_arch_pkg::word_t    data;
        test_name = "random_gprs";
        for (int i = 0; i < 43; i++) begin
            @(negedge clk);
            check_bit($sformatf("next_inst cycle %0d", i), i >= 2 && i < 42, next_inst);
            check_bit("redirect_valid", 1'b0, redirect_valid);
            if (i < 40) begin
                lcg = lcg_step(lcg);
                rd = lcg[27:23];
                lcg = lcg_step(lcg);
                data = lcg;
                present_packet(wb_ctrl_pkg::OP_NONE, 32'h8000_2000 + 4 * i, 1'b1, rd, data,
                               '0, '0);
            end else begin
                ex_valid = 1'b0;
            end
        end
        for (int r = 0; r < 32; r++) begin
            if (gpr_known[r]) begin
                read_gpr(rv_arch_pkg::reg_idx_t'(r), gpr_model[r]);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        ex_valid = 1'b0;
        ex_pc = '0;
        ex_rd_wen = 1'b0;
        ex_rd = '0;
        ex_result = '0;
        ex_op = wb_ctrl_pkg::OP_NONE;
        ex_csr_addr = '0;
        ex_csr_wdata = '0;
        raddr1 = '0;
        raddr2 = '0;
        csr_raddr = '0;
        gpr_model[0] = '0; // x0 is the only GPR known before any write.
        gpr_known[0] = 1'b1;
        test_reset();
        test_gpr();
        test_csr();
        test_ecall();
        test_mret();
        test_random_gprs();
        $display("all tests passed");
        $finish;
    end

endmodule
